// ==== hw/barrett_pkg.sv ====
// Package with default modulus width and value, the mu constant function and FSM states

`default_nettype none

package barrett_pkg;

  // ------------------------------
  // defaults for the reducer
  // ------------------------------
  localparam int          DEF_MOD_BITS = 16;     // modulus width K
  localparam int unsigned DEF_MODULUS  = 65521;  // largest 16 bit prime, odd as required

  // floor(4^k / p), the Barrett constant
  // the result fits in k+1 bits and the caller keeps only those
  // 4^k has to fit in 64 bits, so this holds for k up to 31
  function automatic logic [63:0] barrett_mu(input int unsigned k, input int unsigned p);
    logic [63:0] num;
    num = 64'd1 << (2 * k);
    return num / 64'(p);
  endfunction

  // ------------------------------
  // controller states
  // ------------------------------
  typedef enum logic [2:0] {
    IDLE,       // waiting for an input word
    MUL1_REQ,   // request q1 * mu
    MUL1_WAIT,  // wait for q2
    SHIFT,      // q3 = q2 >> (k+1)
    MUL2_REQ,   // request q3 * p
    MUL2_WAIT,  // wait for the product, then subtract it
    CORRECT,    // subtract p while the remainder is still at least p
    DONE        // result offered on the output
  } ctrl_state_t;

endpackage

`default_nettype wire

// ==== hw/shift_add_mult.sv ====
// Multi-cycle unsigned shift-add multiplier with iteration counter and val/rdy handshake

`default_nettype none

module shift_add_mult #(
  parameter int MUL_BITS = 17
) (
  input  wire logic                    i_clk,
  input  wire logic                    i_rst,
  input  wire logic [MUL_BITS-1:0]     i_a,
  input  wire logic [MUL_BITS-1:0]     i_b,
  input  wire logic                    i_val,
  output logic                         o_rdy,
  output logic                         o_val,
  output logic      [2*MUL_BITS-1:0]   o_prod,
  input  wire logic                    i_rdy
);

  localparam int PROD_BITS = 2 * MUL_BITS;
  localparam int CNT_BITS  = $clog2(MUL_BITS + 1);

  logic [PROD_BITS-1:0] mcand_q;   // multiplicand, moves one place left per step
  logic [MUL_BITS-1:0]  mplier_q;  // multiplier, lsb is the bit being processed
  logic [PROD_BITS-1:0] acc_q;     // running sum of partial products
  logic [CNT_BITS-1:0]  cnt_q;     // bits still to process
  logic                 busy_q;
  logic                 val_q;
  logic                 accept;
  logic                 step;

  assign o_rdy  = ~busy_q & ~val_q;  // idle only
  assign accept = i_val & o_rdy;
  assign step   = busy_q & (cnt_q != '0);
  assign o_val  = val_q;
  assign o_prod = acc_q;             // acc is untouched until the next request

  // ------------------------------
  // control
  // ------------------------------
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      busy_q <= 1'b0;
      val_q  <= 1'b0;
      cnt_q  <= '0;
    end else begin
      if (accept) begin
        busy_q <= 1'b1;
        cnt_q  <= CNT_BITS'(MUL_BITS);
      end else if (busy_q) begin
        if (cnt_q == '0) begin
          busy_q <= 1'b0;                   // one cycle past the last add
          val_q  <= 1'b1;
        end else begin
          cnt_q <= cnt_q - CNT_BITS'(1);
        end
      end else if (val_q && i_rdy) begin
        val_q <= 1'b0;                      // product taken
      end
    end
  end

  // ------------------------------
  // operands and accumulator
  // ------------------------------
  always_ff @(posedge i_clk) begin
    if (accept) begin
      mcand_q  <= {{MUL_BITS{1'b0}}, i_a};
      mplier_q <= i_b;
      acc_q    <= '0;
    end else if (step) begin
      if (mplier_q[0]) begin
        acc_q <= acc_q + mcand_q;           // add only for set multiplier bits
      end
      mcand_q  <= mcand_q << 1;
      mplier_q <= mplier_q >> 1;
    end
  end

endmodule

`default_nettype wire

// ==== hw/barrett_datapath.sv ====
// Barrett datapath: x, q3 and remainder registers, operand select, subtract and compare

`default_nettype none

module barrett_datapath #(
  parameter int          MOD_BITS = 16,
  parameter int unsigned MODULUS  = 65521
) (
  input  wire logic                    i_clk,
  input  wire logic                    i_rst,
  input  wire logic [2*MOD_BITS-1:0]   i_dat,
  input  wire logic                    i_load_x,
  input  wire logic                    i_op_sel,
  input  wire logic                    i_cap_q,
  input  wire logic                    i_cap_sub,
  input  wire logic                    i_corr,
  input  wire logic [2*MOD_BITS+1:0]   i_prod,
  output logic      [MOD_BITS:0]       o_op_a,
  output logic      [MOD_BITS:0]       o_op_b,
  output logic                         o_ge_mod,
  output logic      [MOD_BITS-1:0]     o_res
);

  import barrett_pkg::*;

  localparam int IN_BITS   = 2 * MOD_BITS;
  localparam int OP_BITS   = MOD_BITS + 1;
  localparam int PROD_BITS = 2 * MOD_BITS + 2;

  // ------------------------------
  // constants
  // ------------------------------
  localparam logic [OP_BITS-1:0] MU    = OP_BITS'(barrett_mu(MOD_BITS, MODULUS));
  localparam logic [OP_BITS-1:0] P_OP  = OP_BITS'(MODULUS);   // p as a multiplier operand
  localparam logic [IN_BITS-1:0] P_EXT = IN_BITS'(MODULUS);   // p at remainder width

  logic [IN_BITS-1:0] x_q;     // input word
  logic [OP_BITS-1:0] q3_q;    // quotient estimate
  logic [IN_BITS-1:0] rem_q;   // running remainder
  logic [OP_BITS-1:0] q1;
  logic [OP_BITS-1:0] q2_shr;
  logic [IN_BITS-1:0] prod_lo;

  // q1 = x >> (k-1), always k+1 bits
  assign q1 = x_q[IN_BITS-1:MOD_BITS-1];

  // q2 >> (k+1) is the top k+1 bits of the product
  assign q2_shr = i_prod[PROD_BITS-1:OP_BITS];

  // q3 * p never exceeds x, so the top two product bits are zero here
  assign prod_lo = i_prod[IN_BITS-1:0];

  // ------------------------------
  // operand selection
  // ------------------------------
  always_comb begin
    if (i_op_sel) begin
      o_op_a = q3_q;   // second pass: q3 * p
      o_op_b = P_OP;
    end else begin
      o_op_a = q1;     // first pass: q1 * mu
      o_op_b = MU;
    end
  end

  // ------------------------------
  // registers
  // ------------------------------
  always_ff @(posedge i_clk) begin
    if (i_load_x) begin
      x_q <= i_dat;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_cap_q) begin
      q3_q <= q2_shr;
    end
  end

  // remainder starts as x, loses q3 * p, then up to two copies of p
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      rem_q <= '0;
    end else if (i_load_x) begin
      rem_q <= i_dat;
    end else if (i_cap_sub) begin
      rem_q <= rem_q - prod_lo;
    end else if (i_corr) begin
      rem_q <= rem_q - P_EXT;
    end
  end

  // ------------------------------
  // compare and result
  // ------------------------------
  assign o_ge_mod = (rem_q >= P_EXT);
  assign o_res    = rem_q[MOD_BITS-1:0];  // below p once the corrections are done

endmodule

`default_nettype wire

// ==== hw/barrett_ctrl.sv ====
// Barrett reducer FSM: multiplier requests, correction loop and external handshake

`default_nettype none

module barrett_ctrl (
  input  wire logic i_clk,
  input  wire logic i_rst,
  input  wire logic i_val,
  output logic      o_rdy,
  output logic      o_val,
  input  wire logic i_rdy,
  output logic      o_mul_val,
  input  wire logic i_mul_rdy,
  input  wire logic i_mul_val,
  output logic      o_mul_rdy,
  output logic      o_load_x,
  output logic      o_op_sel,
  output logic      o_cap_q,
  output logic      o_cap_sub,
  output logic      o_corr,
  input  wire logic i_ge_mod
);

  import barrett_pkg::*;

  ctrl_state_t state_q;
  ctrl_state_t state_d;

  // ------------------------------
  // next state and strobes
  // ------------------------------
  always_comb begin
    state_d   = state_q;
    o_mul_val = 1'b0;
    o_mul_rdy = 1'b0;
    o_load_x  = 1'b0;
    o_op_sel  = 1'b0;
    o_cap_q   = 1'b0;
    o_cap_sub = 1'b0;
    o_corr    = 1'b0;
    case (state_q)
      IDLE: begin
        if (i_val && o_rdy) begin
          o_load_x = 1'b1;                  // take the word into x and the remainder
          state_d  = MUL1_REQ;
        end
      end
      MUL1_REQ: begin
        o_mul_val = 1'b1;                   // q1 * mu
        if (i_mul_rdy) begin
          state_d = MUL1_WAIT;
        end
      end
      MUL1_WAIT: begin
        o_mul_rdy = 1'b1;                   // product taken the first cycle it shows
        if (i_mul_val) begin
          state_d = SHIFT;
        end
      end
      SHIFT: begin
        o_cap_q = 1'b1;                     // multiplier holds q2 while idle
        state_d = MUL2_REQ;
      end
      MUL2_REQ: begin
        o_op_sel  = 1'b1;
        o_mul_val = 1'b1;                   // q3 * p
        if (i_mul_rdy) begin
          state_d = MUL2_WAIT;
        end
      end
      MUL2_WAIT: begin
        o_op_sel  = 1'b1;
        o_mul_rdy = 1'b1;
        if (i_mul_val) begin
          o_cap_sub = 1'b1;
          state_d   = CORRECT;
        end
      end
      CORRECT: begin
        // runs at most twice
        if (i_ge_mod) begin
          o_corr = 1'b1;
        end else begin
          state_d = DONE;
        end
      end
      DONE: begin
        if (o_val && i_rdy) begin
          state_d = IDLE;                   // result taken
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  // ------------------------------
  // state and handshake flags
  // ------------------------------
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state_q <= IDLE;
      o_rdy   <= 1'b0;                      // rises one cycle after reset
      o_val   <= 1'b0;
    end else begin
      state_q <= state_d;
      o_rdy   <= (state_d == IDLE);
      o_val   <= (state_d == DONE);         // held under back-pressure
    end
  end

endmodule

`default_nettype wire

// ==== hw/barrett_mod_top.sv ====
// Barrett modular reducer top: controller, datapath and shared shift-add multiplier

`default_nettype none

module barrett_mod_top #(
  parameter int          MOD_BITS = barrett_pkg::DEF_MOD_BITS,
  parameter int unsigned MODULUS  = barrett_pkg::DEF_MODULUS
) (
  input  wire logic                    i_clk,
  input  wire logic                    i_rst,
  input  wire logic [2*MOD_BITS-1:0]   i_dat,
  input  wire logic                    i_val,
  output logic                         o_rdy,
  output logic      [MOD_BITS-1:0]     o_dat,
  output logic                         o_val,
  input  wire logic                    i_rdy
);

  localparam int MUL_BITS = MOD_BITS + 1;   // q1, q3, mu and p are all k+1 bits

  logic [MUL_BITS-1:0]   op_a;
  logic [MUL_BITS-1:0]   op_b;
  logic [2*MUL_BITS-1:0] prod;
  logic                  mul_req_val;
  logic                  mul_req_rdy;
  logic                  mul_res_val;
  logic                  mul_res_rdy;
  logic                  load_x;
  logic                  op_sel;
  logic                  cap_q;
  logic                  cap_sub;
  logic                  corr;
  logic                  ge_mod;

  barrett_ctrl barrett_ctrl_i (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_val     (i_val),
    .o_rdy     (o_rdy),
    .o_val     (o_val),
    .i_rdy     (i_rdy),
    .o_mul_val (mul_req_val),
    .i_mul_rdy (mul_req_rdy),
    .i_mul_val (mul_res_val),
    .o_mul_rdy (mul_res_rdy),
    .o_load_x  (load_x),
    .o_op_sel  (op_sel),
    .o_cap_q   (cap_q),
    .o_cap_sub (cap_sub),
    .o_corr    (corr),
    .i_ge_mod  (ge_mod)
  );

  barrett_datapath #(
    .MOD_BITS (MOD_BITS),
    .MODULUS  (MODULUS)
  ) barrett_datapath_i (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_dat     (i_dat),
    .i_load_x  (load_x),
    .i_op_sel  (op_sel),
    .i_cap_q   (cap_q),
    .i_cap_sub (cap_sub),
    .i_corr    (corr),
    .i_prod    (prod),
    .o_op_a    (op_a),
    .o_op_b    (op_b),
    .o_ge_mod  (ge_mod),
    .o_res     (o_dat)     // remainder drives the output word directly
  );

  shift_add_mult #(
    .MUL_BITS (MUL_BITS)
  ) shift_add_mult_i (
    .i_clk  (i_clk),
    .i_rst  (i_rst),
    .i_a    (op_a),
    .i_b    (op_b),
    .i_val  (mul_req_val),
    .o_rdy  (mul_req_rdy),
    .o_val  (mul_res_val),
    .o_prod (prod),
    .i_rdy  (mul_res_rdy)
  );

endmodule

`default_nettype wire

// ==== dv/tb_clk_gen.sv ====
// Testbench clock and synchronous reset generator

`default_nettype none

module tb_clk_gen #(
  parameter int HALF_PERIOD = 5,   // ns, gives a 10 ns clock
  parameter int RST_CYCLES  = 4
) (
  output logic o_clk,
  output logic o_rst
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    o_clk = 1'b0;
    forever #(HALF_PERIOD) o_clk = ~o_clk;
  end

  initial begin
    o_rst = 1'b1;
    repeat (RST_CYCLES) @(posedge o_clk);
    #1;
    o_rst = 1'b0;                  // released with the same skew as the stimulus
  end

endmodule

`default_nettype wire

// ==== dv/barrett_tb.sv ====
// Barrett reducer testbench: directed tests, residue model, compare tasks, timeout, summary

`default_nettype none

module barrett_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import barrett_pkg::*;

  localparam int          K          = DEF_MOD_BITS;
  localparam int unsigned P          = DEF_MODULUS;
  localparam int          IN_BITS    = 2 * K;
  localparam int unsigned SEED       = 93211;
  localparam int          RST_CYCLES = 4;

  // ------------------------------
  // run length and timeout
  // ------------------------------
  localparam int NUM_EDGE  = 8;
  localparam int NUM_RAND  = 200;
  localparam int NUM_BP    = 10;
  localparam int NUM_B2B   = 20;
  localparam int BP_MAX    = 12;
  localparam int LAT_BOUND = 2 * (K + 2) + 10;   // two multiplier passes plus control
  localparam int TIMEOUT_CYCLES =
    ((NUM_EDGE + NUM_RAND + NUM_BP + NUM_B2B) * LAT_BOUND + RST_CYCLES + NUM_BP * BP_MAX)
    * 6 / 5;

  logic               clk;
  logic               rst;
  logic [IN_BITS-1:0] dat_in;
  logic               val_in;
  logic               rdy_out;
  logic [K-1:0]       dat_out;
  logic               val_out;
  logic               rdy_in;

  int unsigned cycle_cnt = 0;
  int          check_cnt = 0;
  int          error_cnt = 0;
  int          test_cnt  = 0;

  tb_clk_gen #(
    .HALF_PERIOD (5),
    .RST_CYCLES  (RST_CYCLES)
  ) tb_clk_gen_i (
    .o_clk (clk),
    .o_rst (rst)
  );

  barrett_mod_top #(
    .MOD_BITS (K),
    .MODULUS  (P)
  ) barrett_mod_top_i (
    .i_clk (clk),
    .i_rst (rst),
    .i_dat (dat_in),
    .i_val (val_in),
    .o_rdy (rdy_out),
    .o_dat (dat_out),
    .o_val (val_out),
    .i_rdy (rdy_in)
  );

  // ------------------------------
  // helpers
  // ------------------------------
  function automatic logic [K-1:0] expected_residue(input logic [IN_BITS-1:0] x);
    return K'(x % IN_BITS'(P));   // plain modulo as the reference
  endfunction

  function automatic logic [IN_BITS-1:0] random_word();
    return IN_BITS'({$urandom(), $urandom()});
  endfunction

  task automatic wait_cycle();
    @(posedge clk);
    #1;                            // outputs have settled, inputs change here
  endtask

  task automatic check_res(input string test, input logic [K-1:0] exp, input logic [K-1:0] act);
    check_cnt++;
    if (act !== exp) begin
      error_cnt++;
      $display("ERROR %s: residue expected %0d actual %0d", test, exp, act);
    end
  endtask

  task automatic check_bit(input string test, input string flag, input logic exp,
                           input logic act);
    check_cnt++;
    if (act !== exp) begin
      error_cnt++;
      $display("ERROR %s: %s expected %b actual %b", test, flag, exp, act);
    end
  endtask

  task automatic report_failure(input string test, input string what);
    error_cnt++;
    $display("%s failed: %s", test, what);
  endtask

  task automatic finish_test(input string test, input int checks0, input int errors0);
    test_cnt++;
    $display("test %-14s done, %0d checks, %0d errors", test,
             check_cnt - checks0, error_cnt - errors0);
  endtask

  task automatic send_word(input logic [IN_BITS-1:0] x);
    dat_in = x;
    val_in = 1'b1;
    while (!rdy_out) wait_cycle();
    wait_cycle();                  // accepted at this edge
    val_in = 1'b0;
  endtask

  task automatic reduce_and_check(input string test, input logic [IN_BITS-1:0] x);
    send_word(x);
    while (!val_out) wait_cycle();
    check_res(test, expected_residue(x), dat_out);
    wait_cycle();                  // result taken, i_rdy is high
  endtask

  // ------------------------------
  // directed tests
  // ------------------------------
  task automatic test_reset();
    int   c0;
    int   e0;
    logic rdy_seen;
    c0 = check_cnt;
    e0 = error_cnt;
    rdy_seen = 1'b0;
    @(negedge clk);                // reset is driven by now
    while (rst) begin
      check_bit("reset", "o_val", 1'b0, val_out);
      check_bit("reset", "o_rdy", 1'b0, rdy_out);
      @(negedge clk);
    end
    repeat (2) begin
      wait_cycle();
      check_bit("reset", "o_val", 1'b0, val_out);
      if (rdy_out) rdy_seen = 1'b1;
    end
    if (!rdy_seen) report_failure("reset", "o_rdy did not rise within two cycles of release");
    finish_test("reset", c0, e0);
  endtask

  task automatic test_edge_values();
    int                 c0;
    int                 e0;
    logic [IN_BITS-1:0] vals [NUM_EDGE];
    c0 = check_cnt;
    e0 = error_cnt;
    vals[0] = '0;
    vals[1] = IN_BITS'(1);
    vals[2] = IN_BITS'(P - 1);
    vals[3] = IN_BITS'(P);
    vals[4] = IN_BITS'(P + 1);
    vals[5] = IN_BITS'(2 * P);
    vals[6] = IN_BITS'(64'(P) * 64'(P) - 64'd1);
    vals[7] = '1;                  // largest input word
    foreach (vals[i]) reduce_and_check("edge_values", vals[i]);
    finish_test("edge_values", c0, e0);
  endtask

  task automatic test_random_values();
    int c0;
    int e0;
    c0 = check_cnt;
    e0 = error_cnt;
    repeat (NUM_RAND) reduce_and_check("random_values", random_word());
    finish_test("random_values", c0, e0);
  endtask

  task automatic test_back_pressure();
    int                 c0;
    int                 e0;
    int unsigned        hold;
    logic [IN_BITS-1:0] x;
    logic [K-1:0]       held;
    c0 = check_cnt;
    e0 = error_cnt;
    repeat (NUM_BP) begin
      x      = random_word();
      hold   = 3 + ($urandom() % 10);
      rdy_in = 1'b0;
      send_word(x);
      while (!val_out) wait_cycle();
      held = dat_out;
      repeat (hold) begin
        wait_cycle();
        check_bit("back_pressure", "o_val", 1'b1, val_out);
        check_bit("back_pressure", "o_rdy", 1'b0, rdy_out);
        check_res("back_pressure", held, dat_out);   // data must not move while stalled
      end
      rdy_in = 1'b1;
      check_bit("back_pressure", "o_val", 1'b1, val_out);
      check_res("back_pressure", expected_residue(x), dat_out);
      wait_cycle();
      check_bit("back_pressure", "o_val", 1'b0, val_out);
    end
    finish_test("back_pressure", c0, e0);
  endtask

  task automatic test_back_to_back();
    int                 c0;
    int                 e0;
    int                 got;
    logic [IN_BITS-1:0] words [NUM_B2B];
    logic [K-1:0]       exp_q [$];
    c0  = check_cnt;
    e0  = error_cnt;
    got = 0;
    foreach (words[i]) words[i] = random_word();
    rdy_in = 1'b1;
    fork
      begin
        val_in = 1'b1;             // stays high, a new word follows each acceptance
        foreach (words[i]) begin
          dat_in = words[i];
          while (!rdy_out) wait_cycle();
          exp_q.push_back(expected_residue(words[i]));
          wait_cycle();
        end
        val_in = 1'b0;
      end
      begin
        while (got < NUM_B2B) begin
          if (val_out && rdy_out) begin
            report_failure("back_to_back", "input was ready while a result was pending");
          end
          if (val_out) begin
            if (exp_q.size() == 0) begin
              report_failure("back_to_back", "a result came out with no input pending");
            end else begin
              check_res("back_to_back", exp_q.pop_front(), dat_out);
            end
            got++;
          end
          wait_cycle();
        end
      end
    join
    finish_test("back_to_back", c0, e0);
  endtask

  // ------------------------------
  // run control
  // ------------------------------
  initial begin
    void'($urandom(SEED));
    dat_in = '0;
    val_in = 1'b0;
    rdy_in = 1'b0;
    test_reset();
    rdy_in = 1'b1;
    test_edge_values();
    test_random_values();
    test_back_pressure();
    test_back_to_back();
    $display("summary: %0d tests, %0d checks, %0d errors", test_cnt, check_cnt, error_cnt);
    if (error_cnt == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  initial begin
    ctrl_state_t stuck;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    stuck = barrett_mod_top_i.barrett_ctrl_i.state_q;
    $display("simulation timed out after %0d cycles, controller in state %s",
             cycle_cnt, stuck.name());
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
hw/barrett_pkg.sv
hw/shift_add_mult.sv
hw/barrett_datapath.sv
hw/barrett_ctrl.sv
hw/barrett_mod_top.sv
dv/tb_clk_gen.sv
dv/barrett_tb.sv

// ==== Bender.yml ====
package:
  name: barrett_mod

sources:
  # package first, then leaf modules, then the top level
  - hw/barrett_pkg.sv
  - hw/shift_add_mult.sv
  - hw/barrett_datapath.sv
  - hw/barrett_ctrl.sv
  - hw/barrett_mod_top.sv

  # testbench, top module barrett_tb
  - target: test
    files:
      - dv/tb_clk_gen.sv
      - dv/barrett_tb.sv
